/* ringbuf_daq.f */
rtl/ringbuf_pkg.sv
rtl/ring_mem.sv
rtl/sync_fifo.sv
rtl/ring_sample_writer.sv
rtl/ring_readout_fsm.sv
rtl/ringbuf_top.sv
tb/ringbuf_tb_clk.sv
tb/ringbuf_properties.sv
tb/ringbuf_tb.sv

/* tb/ringbuf_tb.sv */
module ringbuf_tb import ringbuf_pkg::*; ();

	// Rough run length for sizing the watchdog
	localparam int total_samples   = 32 + 200 + int'(warn_level) + 64;
	localparam int total_events    = 1 + 4 + 6 + 3 + trig_q_depth + 6 + 1;
	localparam int watchdog_cycles = 4 * total_samples + 300 * total_events + 100;

	logic                CLK;
	logic                RST_RESYNC;
	logic [sample_w-1:0] sample_data;
	logic                sample_valid;
	logic                trig;
	logic [6:0]          samp_max;
	logic [15:0]         out_data;
	logic                out_last;
	logic                out_valid;
	logic                out_ready;
	logic                trig_busy;
	logic                warn;

	logic [31:0]         lfsr_state = 32'ha401_8a4e;
	logic [sample_w-1:0] hist [$];   // Every sample written by index
	int                  ev_num [$];  // Pending events of the model
	int                  ev_start [$];
	int                  ev_len [$];
	int                  word_pos;     // Word index inside the head event
	int                  evt_next;
	int                  cur_samp_max;
	int                  ready_mode;   // 0 low, 1 high, 2 random
	int                  cnt_prev;     // Written count one cycle back
	int                  cnt_cur;
	int                  dropped;
	logic                saw_busy;
	int                  data_errs;
	int                  last_errs;
	int                  other_errs;

	ringbuf_tb_clk i_clk (.CLK(CLK));

	ringbuf_top i_dut (
		.CLK          (CLK),
		.RST_RESYNC   (RST_RESYNC),
		.sample_data  (sample_data),
		.sample_valid (sample_valid),
		.trig         (trig),
		.samp_max     (samp_max),
		.out_data     (out_data),
		.out_last     (out_last),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.trig_busy    (trig_busy),
		.warn         (warn)
	);

	// Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Compares a transferred word with the model
	task automatic check_transfer();
		logic [15:0] exp_data;
		logic        exp_last;
		if (!(out_valid && out_ready)) return;
		assert (ev_num.size() != 0) else begin
			other_errs++;
			$display("error: a word was transferred while no event was expected");
		end
		if (ev_num.size() == 0) return;
		if (word_pos == 0) begin
			exp_data = 16'(ev_num[0]);  // Header carries the event number
			exp_last = 1'b0;
		end else begin
			exp_data = {4'b0000, hist[ev_start[0] + word_pos - 1]};
			exp_last = (word_pos == ev_len[0]);
		end
		assert (out_data === exp_data) else begin
			data_errs++;
			$display("error: out_data is %h, expected %h (event %0d word %0d)",
				out_data, exp_data, ev_num[0], word_pos);
		end
		assert (out_last === exp_last) else begin
			last_errs++;
			$display("error: out_last is %h, expected %h (event %0d word %0d)",
				out_last, exp_last, ev_num[0], word_pos);
		end
		if (word_pos == ev_len[0]) begin
			void'(ev_num.pop_front());
			void'(ev_start.pop_front());
			void'(ev_len.pop_front());
			word_pos = 0;
		end else begin
			word_pos++;
		end
	endtask

	// One clock of stimulus then trigger bookkeeping and output check
	task automatic drive_cycle(input logic valid, input logic t);
		logic [31:0] s;
		logic [31:0] r;
		int          start_idx;
		@(posedge CLK);
		s         = take_bits(sample_w);
		start_idx = hist.size() - int'(pre_trig);
		cnt_prev  = cnt_cur;
		cnt_cur   = hist.size();
		sample_valid <= valid;
		sample_data  <= s[sample_w-1:0];
		trig         <= t;
		samp_max     <= 7'(cur_samp_max);
		case (ready_mode)
			0: out_ready <= 1'b0;
			1: out_ready <= 1'b1;
			default: begin
				r = take_bits(1);
				out_ready <= r[0];
			end
		endcase
		if (valid) hist.push_back(s[sample_w-1:0]);
		@(negedge CLK);
		if (trig_busy) saw_busy = 1'b1;
		if (t && trig_busy) begin
			dropped++;  // Dropped trigger uses no number
		end else if (t) begin
			ev_num.push_back(evt_next);
			ev_start.push_back(start_idx);
			ev_len.push_back(cur_samp_max);
			evt_next++;
		end
		check_transfer();
	endtask

	// Keeps writing samples until the model expects nothing more
	task automatic drain(input int max_cycles);
		int n;
		n = 0;
		while (ev_num.size() != 0 && n < max_cycles) begin
			drive_cycle(1'b1, 1'b0);
			n++;
		end
		assert (ev_num.size() == 0) else begin
			other_errs++;
			$display("error: readout stalled with %0d events still expected", ev_num.size());
		end
	endtask

	task automatic single_event();
		cur_samp_max = 16;
		ready_mode   = 1;
		drive_cycle(1'b1, 1'b1);
		drain(1000);
	endtask

	task automatic overlapping_triggers();
		cur_samp_max = 24;
		ready_mode   = 1;
		repeat (4) begin
			drive_cycle(1'b1, 1'b1);
			drive_cycle(1'b1, 1'b0);
			drive_cycle(1'b1, 1'b0);
		end
		drain(1000);
	endtask

	task automatic random_backpressure();
		cur_samp_max = 30;
		ready_mode   = 2;
		repeat (6) begin
			drive_cycle(1'b1, 1'b1);
			repeat (9) drive_cycle(1'b1, 1'b0);
		end
		drain(2000);
	endtask

	task automatic varying_samp_max();
		int lens [3] = '{1, 5, 127};
		ready_mode = 1;
		foreach (lens[i]) begin
			cur_samp_max = lens[i];
			drive_cycle(1'b1, 1'b1);
			drain(1000);
		end
	endtask

	task automatic trig_queue_full();
		cur_samp_max = 4;
		ready_mode   = 0;
		dropped      = 0;
		saw_busy     = 1'b0;
		drive_cycle(1'b1, 1'b0);
		repeat (trig_q_depth + 6) begin
			drive_cycle(1'b1, 1'b1);
			drive_cycle(1'b1, 1'b0);
		end
		assert (saw_busy) else begin
			other_errs++;
			$display("error: trig_busy never rose while the trigger queue was filling");
		end
		assert (dropped > 0) else begin
			other_errs++;
			$display("error: no trigger was dropped although the queue should be full");
		end
		ready_mode = 1;
		drain(2000);
		drive_cycle(1'b1, 1'b0);
		assert (trig_busy === 1'b0) else begin
			other_errs++;
			$display("error: trig_busy is %h, expected %h after readout", trig_busy, 1'b0);
		end
	endtask

	task automatic backlog_warning();
		int   start_idx;
		int   n;
		logic exp_warn;
		cur_samp_max = 20;  // Longer than the output queue so the record stays pending
		ready_mode   = 0;
		drive_cycle(1'b1, 1'b1);
		start_idx = ev_start[$];
		n = 0;
		do begin
			drive_cycle(1'b1, 1'b0);
			exp_warn = ((cnt_prev - start_idx) > int'(warn_level));
			assert (warn === exp_warn) else begin
				other_errs++;
				$display("error: warn is %h, expected %h", warn, exp_warn);
			end
			n++;
		end while (!warn && n < int'(warn_level) + 64);
		assert (warn) else begin
			other_errs++;
			$display("error: warn never rose although the backlog passed the limit");
		end
		ready_mode = 1;
		drain(2000);
		drive_cycle(1'b1, 1'b0);
		assert (warn === 1'b0) else begin
			other_errs++;
			$display("error: warn is %h, expected %h after the event drained", warn, 1'b0);
		end
	endtask

	initial begin
		repeat (watchdog_cycles) @(posedge CLK);
		$display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		RST_RESYNC   = 1'b1;
		sample_data  = '0;
		sample_valid = 1'b0;
		trig         = 1'b0;
		samp_max     = 7'd1;
		out_ready    = 1'b0;
		word_pos     = 0;
		evt_next     = 0;
		cur_samp_max = 1;
		ready_mode   = 0;
		cnt_prev     = 0;
		cnt_cur      = 0;
		dropped      = 0;
		saw_busy     = 1'b0;
		data_errs    = 0;
		last_errs    = 0;
		other_errs   = 0;
		repeat (10) @(posedge CLK);
		RST_RESYNC <= 1'b0;
		repeat (32) drive_cycle(1'b1, 1'b0);  // Pre-fill ahead of the first window
		single_event();
		overlapping_triggers();
		random_backpressure();
		varying_samp_max();
		trig_queue_full();
		backlog_warning();
		$display("errors: data %0d, last %0d, other %0d, assertion %0d",
			data_errs, last_errs, other_errs, i_dut.i_props.prop_errs);
		if (data_errs + last_errs + other_errs + i_dut.i_props.prop_errs == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* tb/ringbuf_properties.sv */
module ringbuf_properties (
	input logic        CLK,
	input logic        RST_RESYNC,
	input logic        out_valid,
	input logic        out_ready,
	input logic [15:0] out_data,
	input logic        out_last,
	input logic        trig_q_push,
	input logic        trig_q_full
);

	int prop_errs = 0;  // Failed assertions so far

	// Word must wait unchanged while the sink stalls
	property p_hold_on_stall;
		@(posedge CLK) disable iff (RST_RESYNC)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last);
	endproperty

	property p_last_needs_valid;
		@(posedge CLK) disable iff (RST_RESYNC)
		out_last |-> out_valid;
	endproperty

	property p_no_push_when_full;
		@(posedge CLK) disable iff (RST_RESYNC)
		trig_q_push |-> !trig_q_full;
	endproperty

	a_hold_on_stall: assert property (p_hold_on_stall)
		else begin
			prop_errs++;
			$error("output word changed or vanished while out_ready was low");
		end
	a_last_needs_valid: assert property (p_last_needs_valid)
		else begin
			prop_errs++;
			$error("out_last high without out_valid");
		end
	a_no_push_when_full: assert property (p_no_push_when_full)
		else begin
			prop_errs++;
			$error("trigger queue pushed while full");
		end

endmodule

bind ringbuf_top ringbuf_properties i_props (
	.CLK         (CLK),
	.RST_RESYNC  (RST_RESYNC),
	.out_valid   (out_valid),
	.out_ready   (out_ready),
	.out_data    (out_data),
	.out_last    (out_last),
	.trig_q_push (trig_q_push),
	.trig_q_full (trig_q_full)
);

/* tb/ringbuf_tb_clk.sv */
module ringbuf_tb_clk #(
	parameter int period = 8
) (
	output logic CLK
);

	initial begin
		CLK = 1'b0;
	end

	// Free running, 50 percent duty
	always begin
		#(period / 2) CLK = ~CLK;
	end

endmodule

/* rtl/ringbuf_top.sv */
module ringbuf_top import ringbuf_pkg::*; (
	input  logic                CLK,
	input  logic                RST_RESYNC,
	input  logic [sample_w-1:0] sample_data,
	input  logic                sample_valid,
	input  logic                trig,
	input  logic [6:0]          samp_max,
	output logic [15:0]         out_data,
	output logic                out_last,
	output logic                out_valid,
	input  logic                out_ready,
	output logic                trig_busy,
	output logic                warn
);

	logic                             we;
	logic [ring_aw-1:0]               waddr;
	logic [sample_w-1:0]              wdata;
	logic [ring_aw-1:0]               raddr;
	logic [sample_w-1:0]              rdata;
	logic [ring_aw:0]                 wr_count;
	logic                             trig_q_push;
	logic                             trig_q_pop;
	logic                             trig_q_full;
	logic                             trig_q_empty;
	trig_rec_t                        trig_q_din;
	trig_rec_t                        trig_q_head;
	logic                             out_q_push;
	logic                             out_q_pop;
	logic                             out_q_empty;
	logic [$clog2(out_q_depth+1)-1:0] out_q_free;
	out_word_t                        out_q_word;
	out_word_t                        out_q_head;

	ring_sample_writer i_writer (
		.CLK          (CLK),
		.RST_RESYNC   (RST_RESYNC),
		.sample_data  (sample_data),
		.sample_valid (sample_valid),
		.trig         (trig),
		.we           (we),
		.waddr        (waddr),
		.wdata        (wdata),
		.trig_q_full  (trig_q_full),
		.trig_q_push  (trig_q_push),
		.trig_q_rec   (trig_q_din),
		.wr_count     (wr_count),
		.oldest_start (trig_q_head.start_addr),  // Head is the oldest pending event
		.oldest_valid (~trig_q_empty),
		.warn         (warn)
	);

	ring_mem i_mem (
		.CLK   (CLK),
		.we    (we),
		.waddr (waddr),
		.wdata (wdata),
		.raddr (raddr),
		.rdata (rdata)
	);

	sync_fifo #(
		.payload_t (trig_rec_t),
		.depth     (trig_q_depth)
	) i_trig_q (
		.CLK        (CLK),
		.RST_RESYNC (RST_RESYNC),
		.push       (trig_q_push),
		.din        (trig_q_din),
		.pop        (trig_q_pop),
		.dout       (trig_q_head),
		.full       (trig_q_full),
		.empty      (trig_q_empty),
		.free       ()
	);

	ring_readout_fsm i_readout (
		.CLK          (CLK),
		.RST_RESYNC   (RST_RESYNC),
		.samp_max     (samp_max),
		.trig_q_rec   (trig_q_head),
		.trig_q_empty (trig_q_empty),
		.trig_q_pop   (trig_q_pop),
		.wr_count     (wr_count),
		.raddr        (raddr),
		.rdata        (rdata),
		.out_q_free   (out_q_free),
		.out_q_push   (out_q_push),
		.out_q_word   (out_q_word)
	);

	sync_fifo #(
		.payload_t (out_word_t),
		.depth     (out_q_depth)
	) i_out_q (
		.CLK        (CLK),
		.RST_RESYNC (RST_RESYNC),
		.push       (out_q_push),
		.din        (out_q_word),
		.pop        (out_q_pop),
		.dout       (out_q_head),
		.full       (),
		.empty      (out_q_empty),
		.free       (out_q_free)
	);

	assign trig_busy = trig_q_full;

	// Output stream straight from the queue head
	assign out_valid = ~out_q_empty;
	assign out_q_pop = out_valid & out_ready;
	assign out_data  = out_q_head.data;
	assign out_last  = out_q_head.last & out_valid;

endmodule

/* rtl/ring_readout_fsm.sv */
module ring_readout_fsm import ringbuf_pkg::*; (
	input  logic                           CLK,
	input  logic                           RST_RESYNC,
	input  logic [6:0]                     samp_max,
	input  trig_rec_t                      trig_q_rec,
	input  logic                           trig_q_empty,
	output logic                           trig_q_pop,
	input  logic [ring_aw:0]               wr_count,
	output logic [ring_aw-1:0]             raddr,
	input  logic [sample_w-1:0]            rdata,
	input  logic [$clog2(out_q_depth+1)-1:0] out_q_free,
	output logic                           out_q_push,
	output out_word_t                      out_q_word
);

	localparam int fw = $clog2(out_q_depth+1);

	typedef enum logic [1:0] {
		st_idle,
		st_header,
		st_sampling
	} state_t;

	state_t          state;
	logic [ring_aw:0] rd_pos;      // Read position, same range as wr_count
	logic [ring_aw:0] cand_pos;
	logic [ring_aw:0] cand_diff;
	logic [ring_aw:0] load_pos;
	logic [6:0]      smp_cnt;      // Reads issued in this event
	logic [6:0]      cnt_max;
	logic            rd_valid;     // Read data arrives this cycle
	logic            rd_last;
	logic            room;
	logic            sample_ready;
	logic            hdr_push;
	logic            rd_issue;
	logic            rd_final;
	out_word_t       hdr_word;
	out_word_t       smp_word;

	// Rebuild the top bit of the start position from the write count
	// Start is never more than one ring behind the writer
	assign cand_pos  = {wr_count[ring_aw], trig_q_rec.start_addr};
	assign cand_diff = wr_count - cand_pos;
	assign load_pos  = cand_diff[ring_aw] ? {~wr_count[ring_aw], trig_q_rec.start_addr}
	                                      : cand_pos;

	// A word still in the read pipe needs a slot too
	assign room         = (out_q_free > fw'(rd_valid));
	assign sample_ready = (rd_pos != wr_count);  // Sample at rd_pos already written

	assign hdr_push = (state == st_header) && room;
	assign rd_issue = (state == st_sampling) && room && sample_ready;
	assign rd_final = (smp_cnt == cnt_max - 7'd1);

	assign raddr      = rd_pos[ring_aw-1:0];
	assign trig_q_pop = rd_issue && rd_final;  // Record leaves with its last read

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			state   <= st_idle;
			rd_pos  <= '0;
			smp_cnt <= '0;
			cnt_max <= 7'd1;
		end else begin
			case (state)
				st_idle: begin
					if (!trig_q_empty) state <= st_header;
				end
				st_header: begin
					if (hdr_push) begin
						cnt_max <= samp_max;  // Held for the whole event
						rd_pos  <= load_pos;
						smp_cnt <= '0;
						state   <= st_sampling;
					end
				end
				st_sampling: begin
					if (rd_issue) begin
						rd_pos  <= rd_pos + 1'b1;
						smp_cnt <= smp_cnt + 1'b1;
						if (rd_final) state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Tracks the ring read latency
	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			rd_valid <= 1'b0;
			rd_last  <= 1'b0;
		end else begin
			rd_valid <= rd_issue;
			rd_last  <= rd_issue && rd_final;
		end
	end

	assign hdr_word.hdr  = 1'b1;
	assign hdr_word.last = 1'b0;
	assign hdr_word.data = 16'(trig_q_rec.evt_num);

	assign smp_word.hdr  = 1'b0;
	assign smp_word.last = rd_last;
	assign smp_word.data = {4'b0000, rdata};

	// Header and sample pushes never share a cycle, idle sits between events
	assign out_q_push = hdr_push | rd_valid;
	assign out_q_word = hdr_push ? hdr_word : smp_word;

endmodule

/* rtl/ring_sample_writer.sv */
module ring_sample_writer import ringbuf_pkg::*; (
	input  logic                CLK,
	input  logic                RST_RESYNC,
	input  logic [sample_w-1:0] sample_data,
	input  logic                sample_valid,
	input  logic                trig,
	output logic                we,
	output logic [ring_aw-1:0]  waddr,
	output logic [sample_w-1:0] wdata,
	input  logic                trig_q_full,
	output logic                trig_q_push,
	output trig_rec_t           trig_q_rec,
	output logic [ring_aw:0]    wr_count,
	input  logic [ring_aw-1:0]  oldest_start,
	input  logic                oldest_valid,
	output logic                warn
);

	logic [evt_num_w-1:0] evt_num;       // Next event number to hand out
	logic [ring_aw-1:0]   start_addr;
	logic [ring_aw-1:0]   backlog;
	logic                 warn_next;

	// Write pointer is the low part of the written-sample count
	assign waddr = wr_count[ring_aw-1:0];
	assign we    = sample_valid;
	assign wdata = sample_data;

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_count <= '0;
		end else if (sample_valid) begin
			wr_count <= wr_count + 1'b1;  // Wraps with the ring, one extra bit
		end
	end

	// Window start, wraps modulo the ring size
	assign start_addr = waddr - ring_aw'(pre_trig);

	// Dropped triggers while full take no number
	assign trig_q_push = trig & ~trig_q_full;

	assign trig_q_rec.evt_num    = evt_num;
	assign trig_q_rec.start_addr = start_addr;

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			evt_num <= '0;
		end else if (trig_q_push) begin
			evt_num <= evt_num + 1'b1;
		end
	end

	// Samples written since the oldest pending window start
	assign backlog   = waddr - oldest_start;
	assign warn_next = oldest_valid && (backlog > ring_aw'(warn_level));

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			warn <= 1'b0;
		end else begin
			warn <= warn_next;
		end
	end

endmodule

/* rtl/sync_fifo.sv */
module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  depth     = 8
) (
	input  logic                       CLK,
	input  logic                       RST_RESYNC,
	input  logic                       push,
	input  payload_t                   din,
	input  logic                       pop,
	output payload_t                   dout,
	output logic                       full,
	output logic                       empty,
	output logic [$clog2(depth+1)-1:0] free
);

	localparam int pw = $clog2(depth);
	localparam int cw = $clog2(depth+1);

	payload_t        store [depth];
	logic [pw-1:0]   wr_ptr;
	logic [pw-1:0]   rd_ptr;
	logic [cw-1:0]   count;   // Occupied slots
	logic            do_push;
	logic            do_pop;

	function automatic logic [pw-1:0] ptr_inc(input logic [pw-1:0] ptr);
		if (ptr == pw'(depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	always_ff @(posedge CLK) begin
		if (do_push) begin
			store[wr_ptr] <= din;
		end
	end

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	// First-word fall-through, head visible without a pop
	assign dout  = store[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == cw'(depth));
	assign free  = cw'(depth) - count;

endmodule

/* rtl/ring_mem.sv */
module ring_mem import ringbuf_pkg::*; (
	input  logic                CLK,
	input  logic                we,
	input  logic [ring_aw-1:0]  waddr,
	input  logic [sample_w-1:0] wdata,
	input  logic [ring_aw-1:0]  raddr,
	output logic [sample_w-1:0] rdata
);

	// Maps onto block RAM, one write port and one read port
	logic [sample_w-1:0] mem [2**ring_aw];

	always_ff @(posedge CLK) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Registered read, data one cycle after raddr
	always_ff @(posedge CLK) begin
		rdata <= mem[raddr];
	end

endmodule

/* rtl/ringbuf_pkg.sv */
package ringbuf_pkg;

	// Sample and ring geometry
	localparam int unsigned sample_w = 12;
	localparam int unsigned ring_aw = 12;  // 4096 entries

	// Event window placement
	localparam int unsigned pre_trig = 8;  // Samples before the trigger

	// Backlog level that raises warn
	localparam int unsigned warn_level = 3328;

	localparam int unsigned evt_num_w = 16;

	// Queue depths
	localparam int unsigned trig_q_depth = 8;
	localparam int unsigned out_q_depth = 8;

	// One pending trigger, 28 bits
	typedef struct packed {
		logic [evt_num_w-1:0] evt_num;
		logic [ring_aw-1:0]   start_addr;
	} trig_rec_t;

	// One word of the output stream, 18 bits
	// Header carries the event number, a sample word carries the sample zero extended
	typedef struct packed {
		logic        hdr;
		logic        last;
		logic [15:0] data;
	} out_word_t;

endpackage
